// ==== logic/ntm_fixed_pkg.sv ====
/* Fixed-point format and cosh series constants */

package ntm_fixed_pkg;

  //////////////////////////////////////////////////
  // Number format
  //////////////////////////////////////////////////

  // Default word width of the data path
  localparam int DATA_SIZE_DEFAULT = 32;

  // Fraction bits of the signed fixed-point word
  localparam int FRAC_BITS = 16;

  // 1.0 in the fixed-point format
  localparam logic signed [DATA_SIZE_DEFAULT-1:0] ONE_FIXED = 1 << FRAC_BITS;

  //////////////////////////////////////////////////
  // Taylor series
  //////////////////////////////////////////////////

  // Terms after the constant one, even powers only
  localparam int SERIES_TERMS = 7;

  // Term k is built from term k-1 as t * x^2 / ((2k-1) * 2k)
  // Entry k holds floor(2^FRAC_BITS / ((2k-1) * 2k))
  localparam logic [DATA_SIZE_DEFAULT-1:0] COSH_RECIP [1:SERIES_TERMS] = '{
    32'd32768,  // 1/2
    32'd5461,   // 1/12
    32'd2184,   // 1/30
    32'd1170,   // 1/56
    32'd728,    // 1/90
    32'd496,    // 1/132
    32'd360     // 1/182
  };

  // With |x| <= 4.0 the last term is small against the sum
  // Larger arguments would need range reduction first

endpackage

// ==== logic/ntm_ctrl_pkg.sv ====
/* Sequencer control definitions */

package ntm_ctrl_pkg;

  //////////////////////////////////////////////////
  // Loop indices
  //////////////////////////////////////////////////

  // Width of row and column counters and size inputs
  localparam int CONTROL_SIZE_DEFAULT = 4;

  //////////////////////////////////////////////////
  // Vector sequencer
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    VECTOR_IDLE  = 2'd0,  // waiting for row start
    VECTOR_ISSUE = 2'd1,  // waiting for next element
    VECTOR_WAIT  = 2'd2   // core busy on one element
  } vector_state_t;

  //////////////////////////////////////////////////
  // Matrix sequencer
  //////////////////////////////////////////////////

  // Same step order as the row/column walk
  typedef enum logic [1:0] {
    STARTER_STATE = 2'd0,  // waiting for START
    INPUT_I_STATE = 2'd1,  // first element of a row
    INPUT_J_STATE = 2'd2,  // remaining elements of a row
    ENDER_STATE   = 2'd3   // waiting for the vector result
  } matrix_state_t;

endpackage

// ==== logic/scalar_cosh_core.sv ====
/* Scalar cosh core */

`timescale 1ns/100ps

module scalar_cosh_core #(
  parameter int DATA_SIZE = ntm_fixed_pkg::DATA_SIZE_DEFAULT
) (
  // Global
  input  logic                        CLK,
  input  logic                        RST,

  // Control
  input  logic                        START,
  output logic                        READY,

  // Data
  input  logic signed [DATA_SIZE-1:0] X,
  output logic signed [DATA_SIZE-1:0] Y
);

  import ntm_fixed_pkg::*;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  // Term counter runs 1 .. SERIES_TERMS
  localparam int K_WIDTH = $clog2(SERIES_TERMS + 1);

  localparam logic signed [DATA_SIZE-1:0] ONE_DATA = DATA_SIZE'(ONE_FIXED);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  // Series state
  logic signed [DATA_SIZE-1:0]   square;
  logic signed [DATA_SIZE-1:0]   term;
  logic signed [DATA_SIZE-1:0]   acc;
  logic        [K_WIDTH-1:0]     k;

  // Sequencing
  logic                          busy;
  logic                          coef_phase;
  logic                          out_pend;
  logic                          accept;

  // Shared multiplier
  logic signed [DATA_SIZE-1:0]   coef;
  logic signed [DATA_SIZE-1:0]   mul_a;
  logic signed [DATA_SIZE-1:0]   mul_b;
  logic signed [2*DATA_SIZE-1:0] product;
  logic signed [DATA_SIZE-1:0]   scaled;

  //////////////////////////////////////////////////
  // Multiplier
  //////////////////////////////////////////////////

  // New argument only while fully idle
  assign accept = START && !busy && !out_pend;

  // Reciprocal of (2k-1)*2k for the current term
  assign coef = DATA_SIZE'(COSH_RECIP[k]);

  // Idle squares X, busy alternates x^2 and coefficient
  assign mul_a = busy ? term : X;

  always_comb begin
    if (!busy) begin
      mul_b = X;
    end else if (coef_phase) begin
      mul_b = coef;
    end else begin
      mul_b = square;
    end
  end

  assign product = mul_a * mul_b;

  // Arithmetic shift by FRAC_BITS, truncated to one word
  assign scaled = product[FRAC_BITS +: DATA_SIZE];

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy       <= 1'b0;
      coef_phase <= 1'b0;
      out_pend   <= 1'b0;
      k          <= K_WIDTH'(1);
      READY      <= 1'b0;
      Y          <= '0;
    end else begin
      READY <= 1'b0;

      if (accept) begin
        // Square cycle
        busy       <= 1'b1;
        coef_phase <= 1'b0;
        k          <= K_WIDTH'(1);
      end else if (busy) begin
        coef_phase <= !coef_phase;

        // Term done after its coefficient step
        if (coef_phase) begin
          if (k == K_WIDTH'(SERIES_TERMS)) begin
            busy     <= 1'b0;
            out_pend <= 1'b1;
          end else begin
            k <= k + K_WIDTH'(1);
          end
        end
      end else if (out_pend) begin
        // Output register cycle
        out_pend <= 1'b0;
        READY    <= 1'b1;
        Y        <= acc;
      end
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      square <= scaled;
      term   <= ONE_DATA;
      acc    <= ONE_DATA;
    end else if (busy) begin
      term <= scaled;

      // Sum only finished terms
      if (coef_phase) begin
        acc <= acc + scaled;
      end
    end
  end

endmodule

// ==== logic/vector_cosh_function.sv ====
/* Vector cosh sequencer */

`timescale 1ns/100ps

module vector_cosh_function #(
  parameter int DATA_SIZE    = ntm_fixed_pkg::DATA_SIZE_DEFAULT,
  parameter int CONTROL_SIZE = ntm_ctrl_pkg::CONTROL_SIZE_DEFAULT
) (
  // Global
  input  logic                    CLK,
  input  logic                    RST,

  // Control
  input  logic                    START,
  output logic                    READY,

  input  logic                    DATA_IN_ENABLE,
  output logic                    DATA_OUT_ENABLE,

  // Data
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  input  logic [DATA_SIZE-1:0]    DATA_IN,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  import ntm_ctrl_pkg::*;

  localparam logic [CONTROL_SIZE-1:0] ONE_CONTROL = CONTROL_SIZE'(1);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  vector_state_t         state;

  // Row length and returned results
  logic [CONTROL_SIZE-1:0] size_q;
  logic [CONTROL_SIZE-1:0] count;
  logic                    last_elem;

  // Scalar core
  logic                    core_start;
  logic                    core_ready;
  logic [DATA_SIZE-1:0]    core_x;
  logic [DATA_SIZE-1:0]    core_y;

  assign last_elem = (count == size_q - ONE_CONTROL);

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= VECTOR_IDLE;
      size_q          <= '0;
      count           <= '0;
      core_start      <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Strobes last one cycle
      core_start      <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;

      case (state)
        VECTOR_IDLE: begin
          if (START) begin
            size_q <= SIZE_IN;
            count  <= '0;
            // First element may arrive with START
            if (DATA_IN_ENABLE) begin
              core_start <= 1'b1;
              state      <= VECTOR_WAIT;
            end else begin
              state <= VECTOR_ISSUE;
            end
          end
        end
        VECTOR_ISSUE: begin
          if (DATA_IN_ENABLE) begin
            core_start <= 1'b1;
            state      <= VECTOR_WAIT;
          end
        end
        VECTOR_WAIT: begin
          if (core_ready) begin
            DATA_OUT        <= core_y;
            DATA_OUT_ENABLE <= 1'b1;
            count           <= count + ONE_CONTROL;
            // Row done with this result
            if (last_elem) begin
              READY <= 1'b1;
              state <= VECTOR_IDLE;
            end else begin
              state <= VECTOR_ISSUE;
            end
          end
        end
        default: begin
          state <= VECTOR_IDLE;
        end
      endcase
    end
  end

  // Element register toward the core
  always_ff @(posedge CLK) begin
    if (DATA_IN_ENABLE && (state != VECTOR_WAIT)) begin
      core_x <= DATA_IN;
    end
  end

  //////////////////////////////////////////////////
  // Scalar core
  //////////////////////////////////////////////////

  scalar_cosh_core #(
    .DATA_SIZE(DATA_SIZE)
  ) u_scalar_cosh_core (
    .CLK  (CLK),
    .RST  (RST),
    .START(core_start),
    .READY(core_ready),
    .X    (core_x),
    .Y    (core_y)
  );

endmodule

// ==== logic/matrix_cosh_function.sv ====
/* Matrix cosh sequencer */

`timescale 1ns/100ps

module matrix_cosh_function #(
  parameter int DATA_SIZE    = ntm_fixed_pkg::DATA_SIZE_DEFAULT,
  parameter int CONTROL_SIZE = ntm_ctrl_pkg::CONTROL_SIZE_DEFAULT
) (
  // Global
  input  logic                    CLK,
  input  logic                    RST,

  // Control
  input  logic                    START,
  output logic                    READY,

  input  logic                    DATA_IN_I_ENABLE,
  input  logic                    DATA_IN_J_ENABLE,
  output logic                    DATA_OUT_I_ENABLE,
  output logic                    DATA_OUT_J_ENABLE,

  // Data
  input  logic [CONTROL_SIZE-1:0] SIZE_I_IN,
  input  logic [CONTROL_SIZE-1:0] SIZE_J_IN,
  input  logic [DATA_SIZE-1:0]    DATA_IN,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  import ntm_ctrl_pkg::*;

  localparam logic [CONTROL_SIZE-1:0] ONE_CONTROL = CONTROL_SIZE'(1);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  matrix_state_t           state;

  // Matrix size and walk position
  logic [CONTROL_SIZE-1:0] size_i_q;
  logic [CONTROL_SIZE-1:0] size_j_q;
  logic [CONTROL_SIZE-1:0] index_i;
  logic [CONTROL_SIZE-1:0] index_j;
  logic                    last_row;
  logic                    last_col;

  // Vector block
  logic                    vec_start;
  logic                    vec_in_enable;
  logic                    vec_out_enable;
  logic [DATA_SIZE-1:0]    vec_data;
  logic [DATA_SIZE-1:0]    vec_out;

  // Boundaries taken from the indices only
  assign last_row = (index_i == size_i_q - ONE_CONTROL);
  assign last_col = (index_j == size_j_q - ONE_CONTROL);

  //////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= STARTER_STATE;
      size_i_q          <= '0;
      size_j_q          <= '0;
      index_i           <= '0;
      index_j           <= '0;
      vec_start         <= 1'b0;
      vec_in_enable     <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
    end else begin
      // All strobes are single-cycle
      vec_start         <= 1'b0;
      vec_in_enable     <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;

      case (state)
        STARTER_STATE: begin
          if (START) begin
            size_i_q <= SIZE_I_IN;
            size_j_q <= SIZE_J_IN;
            index_i  <= '0;
            index_j  <= '0;
            state    <= INPUT_I_STATE;
          end
        end
        INPUT_I_STATE: begin
          // Row start also restarts the vector block
          if (DATA_IN_I_ENABLE) begin
            vec_start     <= 1'b1;
            vec_in_enable <= 1'b1;
            state         <= ENDER_STATE;
          end
        end
        INPUT_J_STATE: begin
          if (DATA_IN_J_ENABLE) begin
            vec_in_enable <= 1'b1;
            state         <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          if (vec_out_enable) begin
            DATA_OUT          <= vec_out;
            DATA_OUT_J_ENABLE <= 1'b1;

            if (last_col && last_row) begin
              // Matrix complete
              READY <= 1'b1;
              state <= STARTER_STATE;
            end else if (last_col) begin
              // Row complete, next row
              DATA_OUT_I_ENABLE <= 1'b1;
              index_i           <= index_i + ONE_CONTROL;
              index_j           <= '0;
              state             <= INPUT_I_STATE;
            end else begin
              index_j <= index_j + ONE_CONTROL;
              state   <= INPUT_J_STATE;
            end
          end
        end
        default: begin
          state <= STARTER_STATE;
        end
      endcase
    end
  end

  // Element register toward the vector block
  always_ff @(posedge CLK) begin
    if ((state == INPUT_I_STATE && DATA_IN_I_ENABLE) ||
        (state == INPUT_J_STATE && DATA_IN_J_ENABLE)) begin
      vec_data <= DATA_IN;
    end
  end

  //////////////////////////////////////////////////
  // Vector block
  //////////////////////////////////////////////////

  // Row end is decided above, so the vector READY stays open
  vector_cosh_function #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_vector_cosh_function (
    .CLK            (CLK),
    .RST            (RST),
    .START          (vec_start),
    .READY          (),
    .DATA_IN_ENABLE (vec_in_enable),
    .DATA_OUT_ENABLE(vec_out_enable),
    .SIZE_IN        (size_j_q),
    .DATA_IN        (vec_data),
    .DATA_OUT       (vec_out)
  );

endmodule

// ==== dv/matrix_cosh_sva.sv ====
/* Matrix output strobe assertions */

`timescale 1ns/100ps

module matrix_cosh_sva (
  input logic                        CLK,
  input logic                        RST,
  input logic                        READY,
  input logic                        DATA_OUT_I_ENABLE,
  input logic                        DATA_OUT_J_ENABLE,
  input ntm_ctrl_pkg::matrix_state_t state
);

  import ntm_ctrl_pkg::*;

  // Row mark only together with a result
  row_mark_with_result: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_I_ENABLE |-> DATA_OUT_J_ENABLE)
    else $error("DATA_OUT_I_ENABLE without DATA_OUT_J_ENABLE");

  // Completion rides on the last result
  ready_with_result: assert property (@(posedge CLK) disable iff (RST)
    READY |-> DATA_OUT_J_ENABLE)
    else $error("READY without DATA_OUT_J_ENABLE");

  // The final strobe may overlap the step back into starter
  quiet_in_starter: assert property (@(posedge CLK) disable iff (RST)
    (state == STARTER_STATE && $past(state) == STARTER_STATE)
      |-> !(READY || DATA_OUT_I_ENABLE || DATA_OUT_J_ENABLE))
    else $error("output strobe while the sequencer sits in starter");

endmodule

bind matrix_cosh_function matrix_cosh_sva u_matrix_cosh_sva (
  .CLK              (CLK),
  .RST              (RST),
  .READY            (READY),
  .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
  .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
  .state            (state)
);

// ==== dv/matrix_cosh_tb.sv ====
/* Matrix cosh testbench */

`timescale 1ns/100ps

module matrix_cosh_tb;

  import ntm_fixed_pkg::*;
  import ntm_ctrl_pkg::*;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  localparam int DATA_SIZE    = DATA_SIZE_DEFAULT;
  localparam int CONTROL_SIZE = CONTROL_SIZE_DEFAULT;

  // Core latency plus vector and matrix register stages
  localparam int LATENCY_BOUND  = 2 * SERIES_TERMS + 6;
  localparam int TIMEOUT_CYCLES = LATENCY_BOUND + 40;

  localparam logic [31:0] LFSR_SEED = 32'he889_7603;
  localparam logic [DATA_SIZE-1:0] FOUR_FIXED = DATA_SIZE'(4 << FRAC_BITS);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  logic                    CLK;
  logic                    RST;
  logic                    START;
  logic                    READY;
  logic                    DATA_IN_I_ENABLE;
  logic                    DATA_IN_J_ENABLE;
  logic                    DATA_OUT_I_ENABLE;
  logic                    DATA_OUT_J_ENABLE;
  logic [CONTROL_SIZE-1:0] SIZE_I_IN;
  logic [CONTROL_SIZE-1:0] SIZE_J_IN;
  logic [DATA_SIZE-1:0]    DATA_IN;
  logic [DATA_SIZE-1:0]    DATA_OUT;

  // Expected results, {ready, row mark, value}
  logic [DATA_SIZE+1:0]    exp_q [$];
  logic [DATA_SIZE-1:0]    elems [0:15];
  // DUT results of the current matrix, in arrival order
  logic [DATA_SIZE-1:0]    results [0:15];
  int                      result_count;
  logic [31:0]             lfsr_state;
  int                      error_count;
  int                      timeout_count;
  int                      i_pulses;
  int                      ready_pulses;

  matrix_cosh_function #(
    .DATA_SIZE   (DATA_SIZE),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) DUT (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .READY            (READY),
    .DATA_IN_I_ENABLE (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE (DATA_IN_J_ENABLE),
    .DATA_OUT_I_ENABLE(DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE(DATA_OUT_J_ENABLE),
    .SIZE_I_IN        (SIZE_I_IN),
    .SIZE_J_IN        (SIZE_J_IN),
    .DATA_IN          (DATA_IN),
    .DATA_OUT         (DATA_OUT)
  );

  // 40 ns period
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  // Even-power Taylor series, truncating after every product
  function automatic logic [DATA_SIZE-1:0] cosh_ref(input logic signed [DATA_SIZE-1:0] x);
    longint                      prod;
    logic signed [DATA_SIZE-1:0] sq;
    logic signed [DATA_SIZE-1:0] term;
    logic signed [DATA_SIZE-1:0] acc;
    prod = longint'(x) * longint'(x);
    sq   = DATA_SIZE'(prod >>> FRAC_BITS);
    term = ONE_FIXED;
    acc  = ONE_FIXED;
    for (int k = 1; k <= SERIES_TERMS; k++) begin
      prod = longint'(term) * longint'(sq);
      term = DATA_SIZE'(prod >>> FRAC_BITS);
      prod = longint'(term) * longint'(COSH_RECIP[k]);
      term = DATA_SIZE'(prod >>> FRAC_BITS);
      acc  = acc + term;
    end
    return acc;
  endfunction

  // Galois LFSR, right shift
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Magnitude below 4.0, then a sign bit
  task automatic draw_element(output logic [DATA_SIZE-1:0] x);
    logic [31:0] mag;
    logic [31:0] sgn;
    draw_bits(FRAC_BITS + 2, mag);
    draw_bits(1, sgn);
    x = sgn[0] ? DATA_SIZE'(-mag) : DATA_SIZE'(mag);
  endtask

  task automatic check_value(input string what, input logic [DATA_SIZE-1:0] got,
                             input logic [DATA_SIZE-1:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("error %0t: %s got %h expected %h", $time, what, got, expected);
    end
  endtask

  task automatic end_run();
    $display("Summary: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // Result strobe, sampled on the falling edge
  task automatic wait_result(input int index);
    int cycles;
    cycles = 0;
    @(negedge CLK);
    while (!DATA_OUT_J_ENABLE && cycles < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      cycles++;
    end
    if (!DATA_OUT_J_ENABLE) begin
      $display("Timeout: no DATA_OUT_J_ENABLE for element %0d within %0d cycles",
               index, TIMEOUT_CYCLES);
      timeout_count++;
      end_run();
    end
  endtask

  task automatic start_matrix(input int rows, input int cols);
    @(posedge CLK);
    #2;
    START     = 1'b1;
    SIZE_I_IN = CONTROL_SIZE'(rows);
    SIZE_J_IN = CONTROL_SIZE'(cols);
    @(posedge CLK);
    #2;
    START = 1'b0;
  endtask

  // One-cycle strobe, expectation queued at the same time
  task automatic send_element(input int index, input bit row_start, input bit row_mark,
                              input bit last);
    @(posedge CLK);
    #2;
    DATA_IN          = elems[index];
    DATA_IN_I_ENABLE = row_start;
    DATA_IN_J_ENABLE = !row_start;
    exp_q.push_back({last, row_mark, cosh_ref(elems[index])});
    @(posedge CLK);
    #2;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    wait_result(index);
  endtask

  task automatic run_matrix(input int rows, input int cols);
    bit last_col;
    bit last_row;
    i_pulses     = 0;
    ready_pulses = 0;
    result_count = 0;
    start_matrix(rows, cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        last_col = (c == cols - 1);
        last_row = (r == rows - 1);
        send_element(r * cols + c, c == 0, last_col && !last_row, last_col && last_row);
      end
    end
    // Let the compare process count the final strobe
    @(posedge CLK);
    check_value("row marks per matrix", DATA_SIZE'(i_pulses), DATA_SIZE'(rows - 1));
    check_value("READY pulses per matrix", DATA_SIZE'(ready_pulses), DATA_SIZE'(1));
  endtask

  task automatic run_random_matrix();
    logic [31:0] r;
    logic [31:0] c;
    draw_bits(2, r);
    draw_bits(2, c);
    for (int n = 0; n < 16; n++) begin
      draw_element(elems[n]);
    end
    run_matrix(int'(r) + 1, int'(c) + 1);
  endtask

  // Third element is in flight when RST hits
  task automatic reset_mid_matrix();
    start_matrix(3, 2);
    send_element(0, 1'b1, 1'b0, 1'b0);
    send_element(1, 1'b0, 1'b1, 1'b0);
    @(posedge CLK);
    #2;
    DATA_IN          = elems[2];
    DATA_IN_I_ENABLE = 1'b1;
    @(posedge CLK);
    #2;
    DATA_IN_I_ENABLE = 1'b0;
    repeat (6) @(posedge CLK);
    #2;
    RST = 1'b1;
    exp_q.delete();
    repeat (4) @(posedge CLK);
    #2;
    RST = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////

  initial begin : compare
    logic [DATA_SIZE+1:0] expected;
    forever begin
      @(negedge CLK);
      if (RST) begin
        check_value("DATA_OUT in reset", DATA_OUT, '0);
        check_value("strobes in reset",
                    DATA_SIZE'({READY, DATA_OUT_I_ENABLE, DATA_OUT_J_ENABLE}), '0);
      end else if (DATA_OUT_J_ENABLE) begin
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Result strobe at %0t with no element outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          check_value("DATA_OUT", DATA_OUT, expected[DATA_SIZE-1:0]);
          check_value("DATA_OUT_I_ENABLE", DATA_SIZE'(DATA_OUT_I_ENABLE),
                      DATA_SIZE'(expected[DATA_SIZE]));
          check_value("READY", DATA_SIZE'(READY), DATA_SIZE'(expected[DATA_SIZE+1]));
        end
        if (result_count < 16) begin
          results[result_count] = DATA_OUT;
        end
        result_count++;
        if (DATA_OUT_I_ENABLE) begin
          i_pulses++;
        end
        if (READY) begin
          ready_pulses++;
        end
      end else begin
        // Marks only ride on a result
        check_value("DATA_OUT_I_ENABLE alone", DATA_SIZE'(DATA_OUT_I_ENABLE), '0);
        check_value("READY alone", DATA_SIZE'(READY), '0);
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    SIZE_I_IN        = '0;
    SIZE_J_IN        = '0;
    DATA_IN          = '0;
    lfsr_state       = LFSR_SEED;
    error_count      = 0;
    timeout_count    = 0;
    i_pulses         = 0;
    ready_pulses     = 0;
    result_count     = 0;
    repeat (16) @(posedge CLK);
    #2;
    RST = 1'b0;

    // Corners: zero, +-4.0, a symmetric pair, 1.0
    draw_element(elems[3]);
    elems[0] = '0;
    elems[1] = FOUR_FIXED;
    elems[2] = DATA_SIZE'(-FOUR_FIXED);
    elems[4] = DATA_SIZE'(-elems[3]);
    elems[5] = ONE_FIXED;
    run_matrix(2, 3);

    // Corner results as returned by the DUT
    check_value("cosh of zero", results[0], ONE_FIXED);
    check_value("cosh of 4.0 against -4.0", results[1], results[2]);
    check_value("cosh symmetry", results[3], results[4]);

    // Single element matrix
    draw_element(elems[0]);
    run_matrix(1, 1);

    repeat (20) begin
      run_random_matrix();
    end

    // Abort mid-matrix, then a fresh matrix
    for (int n = 0; n < 16; n++) begin
      draw_element(elems[n]);
    end
    reset_mid_matrix();
    run_random_matrix();

    repeat (4) @(posedge CLK);
    if (exp_q.size() != 0) begin
      error_count++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    end_run();
  end

endmodule

// ==== matrix_cosh_function.f ====
logic/ntm_fixed_pkg.sv
logic/ntm_ctrl_pkg.sv
logic/scalar_cosh_core.sv
logic/vector_cosh_function.sv
logic/matrix_cosh_function.sv
dv/matrix_cosh_sva.sv
dv/matrix_cosh_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module matrix_cosh_tb \
  -f matrix_cosh_function.f -Mdir obj_dir

out=$(./obj_dir/Vmatrix_cosh_tb)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
